/* verilog/sram_pkg.sv */
package sram_pkg;

    ////////////////////////////////////////
    // Array geometry
    ////////////////////////////////////////

    // Access ports, each with its own write queue
    localparam int NUM_PORTS = 4;

    // Interleaved banks, picked by the low address bits
    localparam int NUM_BANKS = 4;
    localparam int BANK_W = 2;

    // Word index inside one bank
    localparam int INDEX_W = 9;
    localparam int BANK_WORDS = 2 ** INDEX_W;

    // Port word address, 2048 words in total
    localparam int ADDR_W = INDEX_W + BANK_W;

    // Data word
    localparam int DATA_W = 32;

    ////////////////////////////////////////
    // Address word
    ////////////////////////////////////////

    // Same bits seen two ways.
    // The flat view is what the ports hand in and the queues store;
    // the fields view is what the arbiter and the read muxes decode.
    // Consecutive word addresses land in consecutive banks
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [INDEX_W-1:0] index;
            logic [BANK_W-1:0]  bank;
        } fields;
    } sram_addr_u;

endpackage

/* verilog/write_head_if.sv */
`timescale 1ns/10ps

interface write_head_if;

    // Head of one port's write queue
    logic valid;
    sram_pkg::sram_addr_u addr;
    logic [sram_pkg::DATA_W-1:0] data;

    // Head consumed at the next rising edge
    logic pop;

    modport queue_side (
        output valid,
        output addr,
        output data,
        input  pop
    );

    modport arbiter_side (
        input  valid,
        input  addr,
        input  data,
        output pop
    );

endinterface

/* verilog/write_queue.sv */
`timescale 1ns/10ps

module write_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input logic clk,
    input logic reset,
    input logic we,
    input sram_pkg::sram_addr_u addr,
    input logic [sram_pkg::DATA_W-1:0] wd,
    write_head_if.queue_side head
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

    // Entry storage
    logic [sram_pkg::ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
    logic [sram_pkg::DATA_W-1:0] data_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic full;
    logic push;
    logic pop;

    assign full = (count == FULL_COUNT);
    assign pop = head.pop;

    // A slot freed by a pop in the same cycle can take the new entry.
    // Otherwise a strobe into a full queue is dropped
    assign push = we && (!full || pop);

    ////////////////////////////////////////
    // Pointers and fill level
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {{PTR_W{1'b0}}, push} - {{PTR_W{1'b0}}, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= addr.flat;
            data_mem[wr_ptr] <= wd;
        end
    end

    ////////////////////////////////////////
    // Head presented to the arbiter
    ////////////////////////////////////////

    // Oldest entry, valid right after the edge that stored it
    assign head.valid = (count != '0);
    assign head.addr.flat = addr_mem[rd_ptr];
    assign head.data = data_mem[rd_ptr];

endmodule

/* verilog/bank_arbiter.sv */
`timescale 1ns/10ps

module bank_arbiter (
    input  logic clk,
    input  logic reset,
    write_head_if.arbiter_side heads [sram_pkg::NUM_PORTS],
    output logic bank_we [sram_pkg::NUM_BANKS],
    output logic [sram_pkg::INDEX_W-1:0] bank_index [sram_pkg::NUM_BANKS],
    output logic [sram_pkg::DATA_W-1:0] bank_data [sram_pkg::NUM_BANKS]
);

    // Queue heads, flattened out of the interface array
    logic head_valid [sram_pkg::NUM_PORTS];
    logic [sram_pkg::BANK_W-1:0] head_bank [sram_pkg::NUM_PORTS];
    logic [sram_pkg::INDEX_W-1:0] head_index [sram_pkg::NUM_PORTS];
    logic [sram_pkg::DATA_W-1:0] head_data [sram_pkg::NUM_PORTS];

    // One-hot port grant per bank
    logic [sram_pkg::NUM_PORTS-1:0] grant [sram_pkg::NUM_BANKS];

    logic [sram_pkg::INDEX_W-1:0] next_index [sram_pkg::NUM_BANKS];
    logic [sram_pkg::DATA_W-1:0] next_data [sram_pkg::NUM_BANKS];
    logic [sram_pkg::NUM_PORTS-1:0] pop;

    for (genvar p = 0; p < sram_pkg::NUM_PORTS; p++) begin : g_head
        assign head_valid[p] = heads[p].valid;
        assign head_bank[p] = heads[p].addr.fields.bank;
        assign head_index[p] = heads[p].addr.fields.index;
        assign head_data[p] = heads[p].data;
        assign heads[p].pop = pop[p];
    end

    ////////////////////////////////////////
    // Fixed priority grant
    ////////////////////////////////////////

    // Lowest port number wins the bank
    always_comb begin
        for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
            grant[b] = '0;
            for (int p = 0; p < sram_pkg::NUM_PORTS; p++) begin
                if (head_valid[p] && head_bank[p] == b[sram_pkg::BANK_W-1:0]
                        && grant[b] == '0) begin
                    grant[b][p] = 1'b1;
                end
            end
        end
    end

    // Granted head's index and data per bank
    always_comb begin
        for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
            next_index[b] = '0;
            next_data[b] = '0;
            for (int p = 0; p < sram_pkg::NUM_PORTS; p++) begin
                if (grant[b][p]) begin
                    next_index[b] = head_index[p];
                    next_data[b] = head_data[p];
                end
            end
        end
    end

    // A head targets a single bank, so at most one grant per port
    always_comb begin
        for (int p = 0; p < sram_pkg::NUM_PORTS; p++) begin
            pop[p] = 1'b0;
            for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
                pop[p] = pop[p] | grant[b][p];
            end
        end
    end

    ////////////////////////////////////////
    // Bank stage
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
                bank_we[b] <= 1'b0;
            end
        end else begin
            for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
                bank_we[b] <= |grant[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < sram_pkg::NUM_BANKS; b++) begin
            if (|grant[b]) begin
                bank_index[b] <= next_index[b];
                bank_data[b] <= next_data[b];
            end
        end
    end

endmodule

/* verilog/bank_array.sv */
`timescale 1ns/10ps

module bank_array (
    input  logic clk,
    input  logic bank_we [sram_pkg::NUM_BANKS],
    input  logic [sram_pkg::INDEX_W-1:0] bank_index [sram_pkg::NUM_BANKS],
    input  logic [sram_pkg::DATA_W-1:0] bank_data [sram_pkg::NUM_BANKS],
    input  sram_pkg::sram_addr_u rd_addr [sram_pkg::NUM_PORTS],
    output logic [sram_pkg::DATA_W-1:0] rd [sram_pkg::NUM_PORTS]
);

    // Word each bank returns for each read port
    wire [sram_pkg::DATA_W-1:0] bank_rd [sram_pkg::NUM_BANKS][sram_pkg::NUM_PORTS];

    ////////////////////////////////////////
    // Bank memories
    ////////////////////////////////////////

    // Bank b holds word addresses b, b+4, b+8, ...
    for (genvar b = 0; b < sram_pkg::NUM_BANKS; b++) begin : g_bank
        logic [sram_pkg::DATA_W-1:0] mem [sram_pkg::BANK_WORDS];

        always_ff @(posedge clk) begin
            if (bank_we[b]) begin
                mem[bank_index[b]] <= bank_data[b];
            end
        end

        for (genvar p = 0; p < sram_pkg::NUM_PORTS; p++) begin : g_read
            assign bank_rd[b][p] = mem[rd_addr[p].fields.index];
        end
    end

    ////////////////////////////////////////
    // Read muxes
    ////////////////////////////////////////

    // Bank field picks which bank answers the port
    always_comb begin
        for (int p = 0; p < sram_pkg::NUM_PORTS; p++) begin
            rd[p] = bank_rd[rd_addr[p].fields.bank][p];
        end
    end

endmodule

/* verilog/banked_sram.sv */
`timescale 1ns/10ps

module banked_sram #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic we [sram_pkg::NUM_PORTS],
    input  logic [sram_pkg::ADDR_W-1:0] addr [sram_pkg::NUM_PORTS],
    input  logic [sram_pkg::DATA_W-1:0] wd [sram_pkg::NUM_PORTS],
    output logic [sram_pkg::DATA_W-1:0] rd [sram_pkg::NUM_PORTS]
);

    // Port addresses in the two-view form
    sram_pkg::sram_addr_u addr_u [sram_pkg::NUM_PORTS];

    // Bank stage write commands
    logic bank_we [sram_pkg::NUM_BANKS];
    logic [sram_pkg::INDEX_W-1:0] bank_index [sram_pkg::NUM_BANKS];
    logic [sram_pkg::DATA_W-1:0] bank_data [sram_pkg::NUM_BANKS];

    // Queue heads toward the arbiter
    write_head_if head_if [sram_pkg::NUM_PORTS] ();

    ////////////////////////////////////////
    // Per-port write queues
    ////////////////////////////////////////

    for (genvar p = 0; p < sram_pkg::NUM_PORTS; p++) begin : g_port
        assign addr_u[p] = sram_pkg::sram_addr_u'(addr[p]);

        write_queue #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) write_queue_i (
            .clk   (clk),
            .reset (reset),
            .we    (we[p]),
            .addr  (addr_u[p]),
            .wd    (wd[p]),
            .head  (head_if[p])
        );
    end

    ////////////////////////////////////////
    // Bank grant and storage
    ////////////////////////////////////////

    bank_arbiter bank_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .heads      (head_if),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_data  (bank_data)
    );

    // Reads use the same port address as the writes
    bank_array bank_array_i (
        .clk        (clk),
        .bank_we    (bank_we),
        .bank_index (bank_index),
        .bank_data  (bank_data),
        .rd_addr    (addr_u),
        .rd         (rd)
    );

endmodule

/* tests/banked_sram_tb.sv */
`timescale 1ns/10ps

module banked_sram_tb;

    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_PORTS = sram_pkg::NUM_PORTS;
    localparam int ADDR_W = sram_pkg::ADDR_W;
    localparam int INDEX_W = sram_pkg::INDEX_W;
    localparam int BANK_W = sram_pkg::BANK_W;
    localparam int DATA_W = sram_pkg::DATA_W;
    localparam int WORDS = 2 ** ADDR_W;
    localparam int BURST_LEN = 8;
    localparam int CYCLE_LIMIT = 2000;
    localparam int SETTLE_NS = 10;

    logic clk;
    logic reset;
    logic we [NUM_PORTS];
    logic [ADDR_W-1:0] addr [NUM_PORTS];
    logic [DATA_W-1:0] wd [NUM_PORTS];
    logic [DATA_W-1:0] rd [NUM_PORTS];

    // Expected memory contents, updated on the edge a write lands
    logic [DATA_W-1:0] ref_mem [WORDS];

    // Burst stimulus
    logic [ADDR_W-1:0] burst_addr [NUM_PORTS][BURST_LEN];
    logic [DATA_W-1:0] burst_data [NUM_PORTS][BURST_LEN];

    integer seed;
    int cycle_count;

    banked_sram #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (
        .clk   (clk),
        .reset (reset),
        .we    (we),
        .addr  (addr),
        .wd    (wd),
        .rd    (rd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation did not finish in time");
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Past the next rising edge, back at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic release_strobes();
        for (int p = 0; p < NUM_PORTS; p++) begin
            we[p] = 1'b0;
        end
    endtask

    task automatic record_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] value);
        ref_mem[a] = value;
    endtask

    task automatic expect_rd(input int p, input logic [DATA_W-1:0] expected);
        assert (rd[p] === expected)
        else begin
            $display("Mismatch on rd[%0d] at address %h: expected %h, actual %h",
                     p, addr[p], expected, rd[p]);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Read data differs from the reference model");
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Port 0 writes, port 1 watches the same word
    task automatic uncontended_latency();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] first;
        logic [DATA_W-1:0] second;
        a = ADDR_W'($random(seed));
        first = DATA_W'($random(seed));
        second = first ^ 32'h5a5a_0ff0;
        next_cycle();
        addr[0] = a;
        addr[1] = a;
        wd[0] = first;
        we[0] = 1'b1;
        next_cycle();
        release_strobes();
        next_cycle();
        next_cycle();
        record_write(a, first);
        // New value strobed at edge k
        wd[0] = second;
        we[0] = 1'b1;
        #SETTLE_NS;
        expect_rd(1, ref_mem[a]);
        next_cycle();
        release_strobes();
        #SETTLE_NS;
        expect_rd(1, ref_mem[a]);
        next_cycle();
        #SETTLE_NS;
        expect_rd(1, ref_mem[a]);
        next_cycle();
        record_write(a, second);
        #SETTLE_NS;
        expect_rd(1, ref_mem[a]);
        expect_rd(0, ref_mem[a]);
    endtask

    // One port per bank, no waiting
    task automatic parallel_banks();
        next_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            addr[p] = {INDEX_W'($random(seed)), BANK_W'(p)};
            wd[p] = DATA_W'($random(seed));
            we[p] = 1'b1;
        end
        next_cycle();
        release_strobes();
        next_cycle();
        next_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            record_write(addr[p], wd[p]);
        end
        #SETTLE_NS;
        for (int p = 0; p < NUM_PORTS; p++) begin
            expect_rd(p, ref_mem[addr[p]]);
        end
    endtask

    // All ports into bank 0, served one per cycle by port number
    task automatic bank_contention();
        logic [INDEX_W-1:0] base;
        base = INDEX_W'($random(seed));
        // First round only loads known old contents
        for (int round = 0; round < 2; round++) begin
            next_cycle();
            for (int p = 0; p < NUM_PORTS; p++) begin
                addr[p] = {base + INDEX_W'(p), 2'b00};
                wd[p] = DATA_W'($random(seed));
                we[p] = 1'b1;
            end
            next_cycle();
            release_strobes();
            for (int j = 1; j <= NUM_PORTS + 1; j++) begin
                next_cycle();
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (j == 2 + p) begin
                        record_write(addr[p], wd[p]);
                    end
                end
                #SETTLE_NS;
                if (round == 1) begin
                    for (int p = 0; p < NUM_PORTS; p++) begin
                        expect_rd(p, ref_mem[addr[p]]);
                    end
                end
            end
        end
    endtask

    // Three back to back writes from port 2 to one word
    task automatic same_port_ordering();
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] values [3];
        a = ADDR_W'($random(seed));
        for (int i = 0; i < 3; i++) begin
            values[i] = DATA_W'($random(seed));
        end
        next_cycle();
        addr[2] = a;
        for (int i = 0; i < 3; i++) begin
            wd[2] = values[i];
            we[2] = 1'b1;
            next_cycle();
        end
        release_strobes();
        // Bank writes trail the strobes by two edges
        for (int j = 2; j < 5; j++) begin
            if (j > 2) begin
                next_cycle();
            end
            record_write(a, values[j - 2]);
            #SETTLE_NS;
            expect_rd(2, ref_mem[a]);
        end
        repeat (2) next_cycle();
        #SETTLE_NS;
        expect_rd(2, values[2]);
    endtask

    // Eight strobes per port, 32 distinct words
    task automatic random_bursts();
        logic taken [WORDS];
        logic [ADDR_W-1:0] a;
        for (int w = 0; w < WORDS; w++) begin
            taken[w] = 1'b0;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                do begin
                    a = ADDR_W'($random(seed));
                end while (taken[a]);
                taken[a] = 1'b1;
                burst_addr[p][i] = a;
                burst_data[p][i] = DATA_W'($random(seed));
            end
        end
        next_cycle();
        for (int i = 0; i < BURST_LEN; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                addr[p] = burst_addr[p][i];
                wd[p] = burst_data[p][i];
                we[p] = 1'b1;
            end
            next_cycle();
        end
        release_strobes();
        // Worst case drain
        repeat (NUM_PORTS * QUEUE_DEPTH + 2) next_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                record_write(burst_addr[p][i], burst_data[p][i]);
            end
        end
        // Every written word through every port
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                for (int q = 0; q < NUM_PORTS; q++) begin
                    addr[q] = burst_addr[p][i];
                end
                #SETTLE_NS;
                for (int q = 0; q < NUM_PORTS; q++) begin
                    expect_rd(q, ref_mem[burst_addr[p][i]]);
                end
                next_cycle();
            end
        end
    endtask

    ////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////

    initial begin
        seed = 32'h4ca5edac;
        reset = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            we[p] = 1'b0;
            addr[p] = '0;
            wd[p] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        uncontended_latency();
        parallel_banks();
        bank_contention();
        same_port_ordering();
        random_bursts();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* tb.f */
verilog/sram_pkg.sv
verilog/write_head_if.sv
verilog/write_queue.sv
verilog/bank_arbiter.sv
verilog/bank_array.sv
verilog/banked_sram.sv
tests/banked_sram_tb.sv

/* Bender.yml */
package:
  name: banked_sram

sources:
  # Design, in compile order
  - files:
      - verilog/sram_pkg.sv
      - verilog/write_head_if.sv
      - verilog/write_queue.sv
      - verilog/bank_arbiter.sv
      - verilog/bank_array.sv
      - verilog/banked_sram.sv

  # Testbench
  - target: test
    files:
      - tests/banked_sram_tb.sv
